// File: common/midi_pkg.sv
package midi_pkg;

    // ------------------------------
    // vector types
    // ------------------------------

    // one byte as it comes off the serial line
    typedef logic [7:0]  midi_byte_t;
    // a data byte with the msb stripped
    typedef logic [6:0]  midi_data_t;
    typedef logic [3:0]  midi_channel_t;
    // bits 6..4 of a status byte
    typedef logic [2:0]  midi_cmd_t;
    // bit n enables channel n
    typedef logic [15:0] chan_mask_t;
    typedef logic [15:0] reg_word_t;
    typedef logic [1:0]  cfg_addr_t;

    // ------------------------------
    // channel-voice commands
    // ------------------------------
    localparam midi_cmd_t CMD_NOTE_OFF      = 3'd0;
    localparam midi_cmd_t CMD_NOTE_ON       = 3'd1;
    localparam midi_cmd_t CMD_POLY_PRESSURE = 3'd2;
    localparam midi_cmd_t CMD_CONTROL       = 3'd3;
    localparam midi_cmd_t CMD_PROGRAM       = 3'd4;
    localparam midi_cmd_t CMD_CHAN_PRESSURE = 3'd5;
    localparam midi_cmd_t CMD_PITCH_BEND    = 3'd6;
    // 0xF0..0xFF, never forms a channel message
    localparam midi_cmd_t CMD_SYSTEM        = 3'd7;

    // ------------------------------
    // register map
    // ------------------------------
    localparam cfg_addr_t REG_CHAN_MASK       = 2'd0;
    localparam cfg_addr_t REG_MSG_COUNT       = 2'd1;
    localparam cfg_addr_t REG_DROP_COUNT      = 2'd2;
    localparam cfg_addr_t REG_FRAME_ERR_COUNT = 2'd3;

endpackage

// File: uart/midi_uart_rx.sv
`timescale 1ns/1ns

module midi_uart_rx #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx,
    output logic                 byte_valid,
    output midi_pkg::midi_byte_t byte_data,
    output logic                 framing_error
);
    import midi_pkg::*;

    localparam int CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int HALF_BIT  = CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    midi_byte_t       shift_reg;

    // ------------------------------
    // input synchronizer
    // ------------------------------
    // line idles high, so the flops come out of reset high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ------------------------------
    // bit timing and framing
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            byte_valid    <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            byte_valid    <= 1'b0;
            framing_error <= 1'b0;
            case (state)
                ST_IDLE: begin
                    clk_cnt <= '0;
                    // falling edge only, a line held low after a bad stop bit is not a start
                    if (rx_prev && !rx_sync) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch filter, start bit must still be low at its middle
                        state   <= rx_sync ? ST_IDLE : ST_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt       <= '0;
                        state         <= ST_IDLE;
                        byte_valid    <= rx_sync;
                        framing_error <= !rx_sync;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == ST_DATA && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    // held until the next good byte
    always_ff @(posedge clk) begin
        if (state == ST_STOP && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && rx_sync) begin
            byte_data <= shift_reg;
        end
    end

    // a frame ends in exactly one of the two outcomes
    a_one_outcome: assert property (
        @(posedge clk) disable iff (reset) !(byte_valid && framing_error)
    );

endmodule

// File: design/midi_decoder.sv
`timescale 1ns/1ns

module midi_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  midi_pkg::midi_byte_t    byte_data,
    input  midi_pkg::chan_mask_t    chan_mask,
    output logic                    msg_valid,
    output logic                    msg_accepted,
    output logic                    msg_dropped,
    output midi_pkg::midi_cmd_t     msg_cmd,
    output midi_pkg::midi_channel_t msg_channel,
    output midi_pkg::midi_data_t    msg_data0,
    output midi_pkg::midi_data_t    msg_data1
);
    import midi_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT_STATUS,
        ST_WAIT_DATA0,
        ST_WAIT_DATA1
    } dec_state_t;

    dec_state_t    state;
    midi_cmd_t     cur_cmd;
    midi_channel_t cur_channel;
    midi_data_t    pend_data0;

    logic is_data;
    logic is_chan_status;
    logic is_sys_common;
    logic one_data_byte;
    logic completes;
    logic chan_enabled;

    // ------------------------------
    // byte classification
    // ------------------------------
    assign is_data        = byte_valid && !byte_data[7];
    assign is_chan_status = byte_valid && byte_data[7] && (byte_data[6:4] != CMD_SYSTEM);
    // 0xF0..0xF7, real-time 0xF8..0xFF falls through untouched
    assign is_sys_common  = byte_valid && (byte_data[7:3] == 5'b11110);

    assign one_data_byte  = (cur_cmd == CMD_PROGRAM) || (cur_cmd == CMD_CHAN_PRESSURE);

    // last data byte of the message currently being built
    assign completes = is_data
                    && ((state == ST_WAIT_DATA1)
                    || (state == ST_WAIT_DATA0 && one_data_byte));

    assign chan_enabled = chan_mask[cur_channel];

    // ------------------------------
    // message assembly FSM
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_WAIT_STATUS;
        end else if (is_chan_status) begin
            // restarts even when a message is half built
            state <= ST_WAIT_DATA0;
        end else if (is_sys_common) begin
            state <= ST_WAIT_STATUS;
        end else if (is_data) begin
            case (state)
                ST_WAIT_DATA0: state <= one_data_byte ? ST_WAIT_STATUS : ST_WAIT_DATA1;
                ST_WAIT_DATA1: state <= ST_WAIT_STATUS;
                // stray data byte
                default:       state <= ST_WAIT_STATUS;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (is_chan_status) begin
            cur_cmd     <= midi_cmd_t'(byte_data[6:4]);
            cur_channel <= midi_channel_t'(byte_data[3:0]);
        end
        if (is_data && state == ST_WAIT_DATA0) begin
            pend_data0 <= midi_data_t'(byte_data[6:0]);
        end
    end

    // ------------------------------
    // emit, filtered by the channel mask
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            msg_valid    <= 1'b0;
            msg_accepted <= 1'b0;
            msg_dropped  <= 1'b0;
        end else begin
            msg_valid    <= completes && chan_enabled;
            msg_accepted <= completes && chan_enabled;
            msg_dropped  <= completes && !chan_enabled;
        end
    end

    // fields only move for messages that are actually presented
    always_ff @(posedge clk) begin
        if (completes && chan_enabled) begin
            msg_cmd     <= cur_cmd;
            msg_channel <= cur_channel;
            if (state == ST_WAIT_DATA0) begin
                msg_data0 <= midi_data_t'(byte_data[6:0]);
                msg_data1 <= '0;
            end else begin
                msg_data0 <= pend_data0;
                msg_data1 <= midi_data_t'(byte_data[6:0]);
            end
        end
    end

    // a message needs at least a status and one data byte, so pulses never touch
    a_valid_single: assert property (
        @(posedge clk) disable iff (reset) msg_valid |=> !msg_valid
    );

    // mask from the register block, as it was on the completing byte
    a_valid_masked: assert property (
        @(posedge clk) disable iff (reset)
        msg_valid |-> ((($past(chan_mask) >> msg_channel) & chan_mask_t'(1)) != '0)
    );

endmodule

// File: design/midi_config_regs.sv
`timescale 1ns/1ns

module midi_config_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_write,
    input  midi_pkg::cfg_addr_t  cfg_addr,
    input  midi_pkg::reg_word_t  cfg_wdata,
    input  logic                 msg_accepted,
    input  logic                 msg_dropped,
    input  logic                 framing_error,
    output midi_pkg::reg_word_t  cfg_rdata,
    output midi_pkg::chan_mask_t chan_mask
);
    import midi_pkg::*;

    // indexed by register address, slot 0 is the mask and has no counter
    reg_word_t  counters [REG_MSG_COUNT:REG_FRAME_ERR_COUNT];
    logic [3:1] count_evt;

    assign count_evt[REG_MSG_COUNT]       = msg_accepted;
    assign count_evt[REG_DROP_COUNT]      = msg_dropped;
    assign count_evt[REG_FRAME_ERR_COUNT] = framing_error;

    // ------------------------------
    // channel mask
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            chan_mask <= '1;
        end else if (cfg_write && cfg_addr == REG_CHAN_MASK) begin
            chan_mask <= chan_mask_t'(cfg_wdata);
        end
    end

    // ------------------------------
    // event counters
    // ------------------------------
    // any write clears, data ignored; clear beats a same-cycle event
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = REG_MSG_COUNT; i <= REG_FRAME_ERR_COUNT; i++) begin
                counters[i] <= '0;
            end
        end else begin
            for (int i = REG_MSG_COUNT; i <= REG_FRAME_ERR_COUNT; i++) begin
                if (cfg_write && cfg_addr == cfg_addr_t'(i)) begin
                    counters[i] <= '0;
                end else if (count_evt[i]) begin
                    // wraps at 16 bits
                    counters[i] <= counters[i] + 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        if (cfg_addr == REG_CHAN_MASK) begin
            cfg_rdata = reg_word_t'(chan_mask);
        end else begin
            cfg_rdata = counters[cfg_addr];
        end
    end

endmodule

// File: design/midi_in_top.sv
`timescale 1ns/1ns

module midi_in_top #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    midi_rx,
    input  logic                    cfg_write,
    input  midi_pkg::cfg_addr_t     cfg_addr,
    input  midi_pkg::reg_word_t     cfg_wdata,
    output midi_pkg::reg_word_t     cfg_rdata,
    output logic                    msg_valid,
    output midi_pkg::midi_cmd_t     msg_cmd,
    output midi_pkg::midi_channel_t msg_channel,
    output midi_pkg::midi_data_t    msg_data0,
    output midi_pkg::midi_data_t    msg_data1
);
    import midi_pkg::*;

    // receiver to decoder
    logic       byte_valid;
    midi_byte_t byte_data;
    logic       framing_error;

    // decoder and register block
    logic       msg_accepted;
    logic       msg_dropped;
    chan_mask_t chan_mask;

    midi_uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .clk           (clk),
        .reset         (reset),
        .rx            (midi_rx),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .framing_error (framing_error)
    );

    midi_decoder u_decoder (
        .clk          (clk),
        .reset        (reset),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .chan_mask    (chan_mask),
        .msg_valid    (msg_valid),
        .msg_accepted (msg_accepted),
        .msg_dropped  (msg_dropped),
        .msg_cmd      (msg_cmd),
        .msg_channel  (msg_channel),
        .msg_data0    (msg_data0),
        .msg_data1    (msg_data1)
    );

    midi_config_regs u_config_regs (
        .clk           (clk),
        .reset         (reset),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .msg_accepted  (msg_accepted),
        .msg_dropped   (msg_dropped),
        .framing_error (framing_error),
        .cfg_rdata     (cfg_rdata),
        .chan_mask     (chan_mask)
    );

endmodule

// File: tests/midi_ref.svh
`ifndef MIDI_REF_SVH
`define MIDI_REF_SVH

// one message as it should appear on the msg_* outputs
typedef struct packed {
    midi_cmd_t     cmd;
    midi_channel_t channel;
    midi_data_t    data0;
    midi_data_t    data1;
} exp_msg_t;

// program change and channel pressure carry one data byte, the others two
function automatic int data_bytes_needed(input midi_cmd_t cmd);
    if (cmd == CMD_PROGRAM || cmd == CMD_CHAN_PRESSURE) begin
        return 1;
    end
    return 2;
endfunction

function automatic bit mask_accepts(input chan_mask_t mask, input midi_channel_t channel);
    return mask[channel];
endfunction

// data1 reads zero on one-byte messages
function automatic exp_msg_t expected_msg(input midi_cmd_t cmd, input midi_channel_t channel,
                                          input midi_data_t data0, input midi_data_t data1);
    exp_msg_t m;
    m.cmd     = cmd;
    m.channel = channel;
    m.data0   = data0;
    m.data1   = (data_bytes_needed(cmd) == 1) ? '0 : data1;
    return m;
endfunction

`endif

// File: tests/midi_in_tb.sv
`timescale 1ns/1ns

module midi_in_tb;
    import midi_pkg::*;

    `include "midi_ref.svh"

    localparam int CLKS_PER_BIT   = 16;
    localparam int CLK_NS         = 10;
    localparam int RANDOM_BYTES   = 300;
    // bad frames count twice because of the idle bit time after them
    localparam int DIRECTED_BYTES = 58;
    localparam int WATCHDOG_NS    = (DIRECTED_BYTES + RANDOM_BYTES) * 10 * CLKS_PER_BIT
                                    * CLK_NS * 2 + 20000;

    logic          clk;
    logic          reset;
    logic          midi_rx;
    logic          cfg_write;
    cfg_addr_t     cfg_addr;
    reg_word_t     cfg_wdata;
    reg_word_t     cfg_rdata;
    logic          msg_valid;
    midi_cmd_t     msg_cmd;
    midi_channel_t msg_channel;
    midi_data_t    msg_data0;
    midi_data_t    msg_data1;

    // reference model state
    exp_msg_t      exp_q[$];
    exp_msg_t      mon_exp;
    bit            ref_busy;
    bit            ref_have_d0;
    midi_cmd_t     ref_cmd;
    midi_channel_t ref_chan;
    midi_data_t    ref_d0;
    chan_mask_t    ref_mask;
    reg_word_t     ref_accepted;
    reg_word_t     ref_dropped;
    reg_word_t     ref_frame_err;

    string         cur_test;
    int            err_count;
    int            test_err_start;
    int            tests_run;
    int            tests_failed;
    int unsigned   seed;
    int unsigned   rand_word;
    midi_byte_t    rand_byte;

    midi_in_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .midi_rx     (midi_rx),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .msg_valid   (msg_valid),
        .msg_cmd     (msg_cmd),
        .msg_channel (msg_channel),
        .msg_data0   (msg_data0),
        .msg_data1   (msg_data1)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // start bit, eight data bits lsb first, stop bit
    task automatic send_byte(input midi_byte_t b, input bit bad_stop);
        midi_rx = 1'b0;
        wait_clks(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            midi_rx = b[i];
            wait_clks(CLKS_PER_BIT);
        end
        midi_rx = !bad_stop;
        wait_clks(CLKS_PER_BIT);
        if (bad_stop) begin
            // line back high so the next start bit has an edge
            midi_rx = 1'b1;
            wait_clks(CLKS_PER_BIT);
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input reg_word_t data);
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_write = 1'b1;
        wait_clks(1);
        cfg_write = 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output reg_word_t value);
        cfg_addr = addr;
        wait_clks(1);
        value = cfg_rdata;
    endtask

    // status, data, system common and real-time bytes in a 3:3:1:1 mix
    function automatic midi_byte_t random_midi_byte();
        int unsigned kind;
        kind = $urandom % 8;
        if (kind < 3) begin
            return midi_byte_t'(32'h80 + ($urandom % 32'd112));
        end else if (kind < 6) begin
            return midi_byte_t'($urandom % 32'd128);
        end else if (kind == 6) begin
            return midi_byte_t'(32'hF0 + ($urandom % 32'd8));
        end
        return midi_byte_t'(32'hF8 + ($urandom % 32'd8));
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic finish_msg(input midi_data_t d0, input midi_data_t d1);
        if (mask_accepts(ref_mask, ref_chan)) begin
            exp_q.push_back(expected_msg(ref_cmd, ref_chan, d0, d1));
            ref_accepted++;
        end else begin
            ref_dropped++;
        end
        ref_busy = 1'b0;
    endtask

    task automatic model_byte(input midi_byte_t b);
        if (b >= 8'h80 && b <= 8'hEF) begin
            ref_cmd     = b[6:4];
            ref_chan    = b[3:0];
            ref_busy    = 1'b1;
            ref_have_d0 = 1'b0;
        end else if (b >= 8'hF0 && b <= 8'hF7) begin
            ref_busy = 1'b0;
        end else if (b < 8'h80 && ref_busy) begin
            if (!ref_have_d0 && data_bytes_needed(ref_cmd) == 2) begin
                ref_d0      = b[6:0];
                ref_have_d0 = 1'b1;
            end else begin
                finish_msg(ref_have_d0 ? ref_d0 : b[6:0], b[6:0]);
            end
        end
        // real-time bytes leave the model untouched
    endtask

    task automatic send(input midi_byte_t b);
        model_byte(b);
        send_byte(b, 1'b0);
    endtask

    task automatic send_bad(input midi_byte_t b);
        ref_frame_err++;
        send_byte(b, 1'b1);
    endtask

    task automatic set_mask(input chan_mask_t mask);
        write_reg(REG_CHAN_MASK, reg_word_t'(mask));
        ref_mask = mask;
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    task automatic check_msg(input midi_cmd_t exp_cmd, input midi_channel_t exp_ch,
                             input midi_data_t exp_d0, input midi_data_t exp_d1,
                             input midi_cmd_t act_cmd, input midi_channel_t act_ch,
                             input midi_data_t act_d0, input midi_data_t act_d1);
        string exp_s;
        string act_s;
        if (act_cmd !== exp_cmd || act_ch !== exp_ch || act_d0 !== exp_d0
            || act_d1 !== exp_d1) begin
            exp_s = $sformatf("cmd %0d ch %0d data %02h %02h",
                              exp_cmd, exp_ch, exp_d0, exp_d1);
            act_s = $sformatf("cmd %0d ch %0d data %02h %02h",
                              act_cmd, act_ch, act_d0, act_d1);
            $display("[FAIL] %s: expected %s, actual %s", cur_test, exp_s, act_s);
            err_count++;
        end
    endtask

    task automatic check_reg(input cfg_addr_t addr, input reg_word_t expected);
        reg_word_t actual;
        read_reg(addr, actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: register %0d expected %04h, actual %04h",
                     cur_test, addr, expected, actual);
            err_count++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && msg_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: a message came out on channel %0d when none was expected",
                         cur_test, msg_channel);
                err_count++;
            end else begin
                mon_exp = exp_q.pop_front();
                check_msg(mon_exp.cmd, mon_exp.channel, mon_exp.data0, mon_exp.data1,
                          msg_cmd, msg_channel, msg_data0, msg_data1);
            end
        end
    end

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        wait_clks(4);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected messages never came out", cur_test, exp_q.size());
            err_count++;
            exp_q.delete();
        end
        tests_run++;
        if (err_count != test_err_start) begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, err_count - test_err_start);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        seed          = 32'hb338_d334;
        rand_word     = $urandom(seed);
        reset         = 1'b1;
        midi_rx       = 1'b1;
        cfg_write     = 1'b0;
        cfg_addr      = REG_CHAN_MASK;
        cfg_wdata     = '0;
        ref_busy      = 1'b0;
        ref_have_d0   = 1'b0;
        ref_mask      = '1;
        ref_accepted  = '0;
        ref_dropped   = '0;
        ref_frame_err = '0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_clks(2);

        start_test("two_byte_msgs");
        send(8'h90);
        send(8'h3C);
        send(8'h64);
        send(8'h85);
        send(8'h40);
        send(8'h00);
        send(8'hBA);
        send(8'h07);
        send(8'h7F);
        send(8'hEF);
        send(8'h00);
        send(8'h40);
        send(8'hA3);
        send(8'h11);
        send(8'h22);
        end_test();

        start_test("one_byte_msgs");
        send(8'hC4);
        send(8'h05);
        send(8'hD9);
        send(8'h33);
        send(8'hCF);
        send(8'h7F);
        end_test();

        start_test("channel_mask");
        set_mask(16'h00F0);
        send(8'h91);
        send(8'h10);
        send(8'h20);
        send(8'h94);
        send(8'h10);
        send(8'h20);
        send(8'hC7);
        send(8'h01);
        send(8'hC8);
        send(8'h02);
        check_reg(REG_CHAN_MASK, reg_word_t'(ref_mask));
        check_reg(REG_MSG_COUNT, ref_accepted);
        check_reg(REG_DROP_COUNT, ref_dropped);
        end_test();

        start_test("byte_rules");
        set_mask('1);
        // second status restarts the half-built message
        send(8'h90);
        send(8'h3C);
        send(8'h92);
        send(8'h40);
        send(8'h50);
        // real-time in the middle is invisible
        send(8'h93);
        send(8'h3C);
        send(8'hF8);
        send(8'h50);
        // system common aborts, the trailing data byte is stray
        send(8'h94);
        send(8'h3C);
        send(8'hF2);
        send(8'h50);
        send(8'h12);
        send(8'h34);
        send(8'h95);
        send(8'hF8);
        send(8'h3C);
        send(8'hF8);
        send(8'h7F);
        end_test();

        start_test("framing");
        send_bad(8'h90);
        send_bad(8'h3C);
        check_reg(REG_FRAME_ERR_COUNT, ref_frame_err);
        send(8'h90);
        send(8'h3C);
        send(8'h64);
        write_reg(REG_MSG_COUNT, 16'hFFFF);
        ref_accepted = '0;
        write_reg(REG_DROP_COUNT, 16'h1234);
        ref_dropped = '0;
        write_reg(REG_FRAME_ERR_COUNT, 16'hA5A5);
        ref_frame_err = '0;
        check_reg(REG_MSG_COUNT, ref_accepted);
        check_reg(REG_DROP_COUNT, ref_dropped);
        check_reg(REG_FRAME_ERR_COUNT, ref_frame_err);
        end_test();

        start_test("random_stream");
        set_mask(chan_mask_t'(rand_word));
        for (int i = 0; i < RANDOM_BYTES; i++) begin
            rand_byte = random_midi_byte();
            send(rand_byte);
        end
        check_reg(REG_MSG_COUNT, ref_accepted);
        check_reg(REG_DROP_COUNT, ref_dropped);
        check_reg(REG_FRAME_ERR_COUNT, ref_frame_err);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+tests
common/midi_pkg.sv
uart/midi_uart_rx.sv
design/midi_decoder.sv
design/midi_config_regs.sv
design/midi_in_top.sv
tests/midi_in_tb.sv
